// ==== logic/pwm_macros.svh ====
// Channel count, bus and counter widths, register offsets
`ifndef PWM_MACROS_SVH
`define PWM_MACROS_SVH

`default_nettype none

// Sizes
`define PWM_NCH 6
`define PWM_DW  32
`define PWM_CW  16

// Global slot registers
`define PWM_ADDR_ENB    2'd0
`define PWM_ADDR_DUPD   2'd1
`define PWM_ADDR_IMASK  2'd2
`define PWM_ADDR_ISTAT  2'd3

// Channel slot registers
`define PWM_ADDR_PERIOD 2'd0
`define PWM_ADDR_HIGH   2'd1
`define PWM_ADDR_MODE   2'd2
`define PWM_ADDR_COUNT  2'd3

`default_nettype wire

`endif

// ==== logic/pwm_pkg.sv ====
// Shared bus word, channel mask, counter and slot select types
`include "pwm_macros.svh"

`default_nettype none

package pwm_pkg;

  // One register bus data word
  typedef logic [`PWM_DW-1:0] reg_word_t;

  // One bit per PWM channel
  typedef logic [`PWM_NCH-1:0] ch_mask_t;

  // Period, high time and counter value
  typedef logic [`PWM_CW-1:0] cnt_t;

  // ----------------------------------------
  // Slot select from address bits 4:2
  // ----------------------------------------
  typedef logic [2:0] blk_sel_t;

  // Global block sits in slot 0
  localparam blk_sel_t BLK_GLBL  = 3'd0;
  // Channel 0 slot, the rest follow
  localparam blk_sel_t BLK_CH0   = 3'd1;
  // Nobody home here
  localparam blk_sel_t BLK_UNMAP = 3'd7;

endpackage

`default_nettype wire

// ==== logic/pwm_reg_if.sv ====
// Register slot interface with master and slave modports
`include "pwm_macros.svh"

`default_nettype none

interface pwm_reg_if;
  import pwm_pkg::*;

  // Request side
  logic                  cs;
  logic                  wr;
  logic [1:0]            addr;
  reg_word_t             wdata;
  logic [`PWM_DW/8-1:0]  be;

  // Response side, registered in the slave
  reg_word_t             rdata;
  logic                  ack;

  // Decoder end
  modport master (output cs, wr, addr, wdata, be, input rdata, ack);

  // Register block end
  modport slave (input cs, wr, addr, wdata, be, output rdata, ack);

endinterface

`default_nettype wire

// ==== logic/pwm_bus_decode.sv ====
// Register bus decoder for the global slot and the channel slots
`include "pwm_macros.svh"

`default_nettype none

module pwm_bus_decode (
  input  logic                 mclk,
  input  logic                 h_reset_n,
  input  logic                 reg_cs,
  input  logic                 reg_wr,
  input  logic [4:0]           reg_addr,
  input  pwm_pkg::reg_word_t   reg_wdata,
  input  logic [`PWM_DW/8-1:0] reg_be,
  output pwm_pkg::reg_word_t   reg_rdata,
  output logic                 reg_ack,
  pwm_reg_if.master            slot [0:`PWM_NCH]
);
  import pwm_pkg::*;

  blk_sel_t         sel;
  logic             unm_ack;
  logic [`PWM_NCH:0] slot_ack;
  reg_word_t        slot_rdata [0:`PWM_NCH];

  // Upper address bits pick the slot
  assign sel = reg_addr[4:2];

  // ----------------------------------------
  // Fan out, only selected slot sees cs
  // ----------------------------------------
  for (genvar i = 0; i <= `PWM_NCH; i++) begin : g_slot
    assign slot[i].cs    = reg_cs && (sel == blk_sel_t'(i));
    assign slot[i].wr    = reg_wr;
    assign slot[i].addr  = reg_addr[1:0];
    assign slot[i].wdata = reg_wdata;
    assign slot[i].be    = reg_be;
    // Collect responses for the mux
    assign slot_ack[i]   = slot[i].ack;
    assign slot_rdata[i] = slot[i].rdata;
  end

  // Unmapped slot still answers, one cycle after cs
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      unm_ack <= 1'b0;
    end else begin
      unm_ack <= reg_cs && (sel == BLK_UNMAP) && !unm_ack;
    end
  end

  // Response mux, follows address held by host
  always_comb begin
    reg_ack   = unm_ack;
    reg_rdata = '0;
    if (sel != BLK_UNMAP) begin
      reg_ack   = slot_ack[sel];
      reg_rdata = slot_rdata[sel];
    end
  end

endmodule

`default_nettype wire

// ==== logic/pwm_glbl_reg.sv ====
// Global enable, freeze, interrupt mask and status registers with interrupt output
`include "pwm_macros.svh"

`default_nettype none

module pwm_glbl_reg (
  input  logic              mclk,
  input  logic              h_reset_n,
  pwm_reg_if.slave          bus,
  output pwm_pkg::ch_mask_t cfg_pwm_enb,
  output pwm_pkg::ch_mask_t cfg_pwm_dupdate,
  input  pwm_pkg::ch_mask_t pwm_os_done,
  input  pwm_pkg::ch_mask_t pwm_ovflow,
  input  pwm_pkg::ch_mask_t gpio_tgr,
  output logic              pwm_intr
);
  import pwm_pkg::*;

  logic      wr_stb;
  ch_mask_t  wr_bits;
  ch_mask_t  enb_r;
  ch_mask_t  dupd_r;
  ch_mask_t  imask_r;
  ch_mask_t  istat_r;
  reg_word_t rd_mux;

  // Write lands in the ack cycle, low byte lane only
  assign wr_stb  = bus.cs & bus.wr & bus.ack & bus.be[0];
  assign wr_bits = bus.wdata[`PWM_NCH-1:0];

  assign cfg_pwm_enb     = enb_r;
  assign cfg_pwm_dupdate = dupd_r;

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      bus.ack <= 1'b0;
    end else begin
      // Never re-raised while high, so one cycle wide
      bus.ack <= bus.cs & ~bus.ack;
    end
  end

  // Read data captured alongside ack
  always_ff @(posedge mclk) begin
    if (bus.cs && !bus.ack) begin
      bus.rdata <= rd_mux;
    end
  end

  // ----------------------------------------
  // Channel enables
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      enb_r <= '0;
    end else if (wr_stb && bus.addr == `PWM_ADDR_ENB) begin
      // Triggers win over a written zero
      enb_r <= wr_bits | gpio_tgr;
    end else begin
      // One-shot completion drops the bit
      enb_r <= (enb_r | gpio_tgr) & ~pwm_os_done;
    end
  end

  // Freeze and mask, plain software registers
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      dupd_r  <= '0;
      imask_r <= '0;
    end else if (wr_stb) begin
      if (bus.addr == `PWM_ADDR_DUPD) dupd_r <= wr_bits;
      if (bus.addr == `PWM_ADDR_IMASK) imask_r <= wr_bits;
    end
  end

  // ----------------------------------------
  // Interrupt status and output
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      istat_r  <= '0;
      pwm_intr <= 1'b0;
    end else begin
      // Hardware set beats software clear
      if (wr_stb && bus.addr == `PWM_ADDR_ISTAT) begin
        istat_r <= (istat_r & ~wr_bits) | pwm_ovflow;
      end else begin
        istat_r <= istat_r | pwm_ovflow;
      end
      // Interrupt follows status one cycle later
      pwm_intr <= |(istat_r & imask_r);
    end
  end

  // Readback, upper bits zero
  always_comb begin
    case (bus.addr)
      `PWM_ADDR_ENB:   rd_mux = reg_word_t'(enb_r);
      `PWM_ADDR_DUPD:  rd_mux = reg_word_t'(dupd_r);
      `PWM_ADDR_IMASK: rd_mux = reg_word_t'(imask_r);
      `PWM_ADDR_ISTAT: rd_mux = reg_word_t'(istat_r);
      default:         rd_mux = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/pwm_chan.sv ====
// PWM channel with shadow config, active config, counter and output pulses
`include "pwm_macros.svh"

`default_nettype none

module pwm_chan (
  input  logic     mclk,
  input  logic     h_reset_n,
  pwm_reg_if.slave bus,
  input  logic     enb,
  input  logic     dupdate,
  output logic     pwm_out,
  output logic     os_done,
  output logic     ovflow
);
  import pwm_pkg::*;

  cnt_t      sh_period;
  cnt_t      sh_high;
  logic      sh_mode;
  cnt_t      act_period;
  cnt_t      act_high;
  cnt_t      cnt;
  logic      run_q;
  logic      last;
  logic      wrap;
  logic      load;
  logic      wr_stb;
  reg_word_t rd_mux;

  // Write lands in the ack cycle
  assign wr_stb = bus.cs & bus.wr & bus.ack;

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.cs & ~bus.ack;
    end
  end

  always_ff @(posedge mclk) begin
    if (bus.cs && !bus.ack) begin
      bus.rdata <= rd_mux;
    end
  end

  // ----------------------------------------
  // Shadow config, byte lane writes
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      sh_period <= '0;
      sh_high   <= '0;
      sh_mode   <= 1'b0;
    end else if (wr_stb) begin
      for (int b = 0; b < `PWM_CW/8; b++) begin
        if (bus.be[b] && bus.addr == `PWM_ADDR_PERIOD) begin
          sh_period[b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
        if (bus.be[b] && bus.addr == `PWM_ADDR_HIGH) begin
          sh_high[b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
      // Mode is a single bit in lane 0
      if (bus.be[0] && bus.addr == `PWM_ADDR_MODE) sh_mode <= bus.wdata[0];
    end
  end

  // ----------------------------------------
  // Counter and active config
  // ----------------------------------------
  // Zero period wraps every cycle
  assign last = (act_period == '0) || (cnt == act_period - 1'b1);
  assign wrap = enb & run_q & last;
  // Reload at first enabled cycle or on wrap, unless frozen
  assign load = enb & ~dupdate & (wrap | ~run_q);

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      run_q      <= 1'b0;
      cnt        <= '0;
      act_period <= '0;
      act_high   <= '0;
    end else begin
      run_q <= enb;
      // Held at 0 while off and in the load cycle
      if (!enb || !run_q || wrap) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      if (load) begin
        act_period <= sh_period;
        act_high   <= sh_high;
      end
    end
  end

  // High while counter below high time
  assign pwm_out = enb & run_q & (cnt < act_high);
  assign ovflow  = wrap;
  // One-shot ends at first wrap
  assign os_done = wrap & sh_mode;

  // Readback, COUNT is live
  always_comb begin
    case (bus.addr)
      `PWM_ADDR_PERIOD: rd_mux = reg_word_t'(sh_period);
      `PWM_ADDR_HIGH:   rd_mux = reg_word_t'(sh_high);
      `PWM_ADDR_MODE:   rd_mux = reg_word_t'(sh_mode);
      `PWM_ADDR_COUNT:  rd_mux = reg_word_t'(cnt);
      default:          rd_mux = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/pwm_subsys.sv ====
// PWM subsystem top with bus decoder, global registers and channel array
`include "pwm_macros.svh"

`default_nettype none

module pwm_subsys (
  input  logic                 mclk,
  input  logic                 h_reset_n,
  input  logic                 reg_cs,
  input  logic                 reg_wr,
  input  logic [4:0]           reg_addr,
  input  pwm_pkg::reg_word_t   reg_wdata,
  input  logic [`PWM_DW/8-1:0] reg_be,
  input  pwm_pkg::ch_mask_t    gpio_tgr,
  output pwm_pkg::reg_word_t   reg_rdata,
  output logic                 reg_ack,
  output pwm_pkg::ch_mask_t    pwm_out,
  output logic                 pwm_intr
);
  import pwm_pkg::*;

  // Channel to global block
  ch_mask_t cfg_pwm_enb;
  ch_mask_t cfg_pwm_dupdate;
  ch_mask_t pwm_os_done;
  ch_mask_t pwm_ovflow;

  // One register slot per block
  pwm_reg_if slot_if [0:`PWM_NCH] ();

  // ----------------------------------------
  // Bus split
  // ----------------------------------------
  pwm_bus_decode u_decode (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .slot      (slot_if)
  );

  // Enables, freeze, interrupt
  pwm_glbl_reg u_glbl (
    .mclk            (mclk),
    .h_reset_n       (h_reset_n),
    .bus             (slot_if[BLK_GLBL]),
    .cfg_pwm_enb     (cfg_pwm_enb),
    .cfg_pwm_dupdate (cfg_pwm_dupdate),
    .pwm_os_done     (pwm_os_done),
    .pwm_ovflow      (pwm_ovflow),
    .gpio_tgr        (gpio_tgr),
    .pwm_intr        (pwm_intr)
  );

  // ----------------------------------------
  // Channels, slot follows global block
  // ----------------------------------------
  for (genvar i = 0; i < `PWM_NCH; i++) begin : g_chan
    pwm_chan u_chan (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .bus       (slot_if[BLK_CH0 + i]),
      .enb       (cfg_pwm_enb[i]),
      .dupdate   (cfg_pwm_dupdate[i]),
      .pwm_out   (pwm_out[i]),
      .os_done   (pwm_os_done[i]),
      .ovflow    (pwm_ovflow[i])
    );
  end

endmodule

`default_nettype wire

// ==== sim/pwm_asserts.sv ====
// Bound checker with bus handshake, reset state, PWM window and interrupt assertions
`include "pwm_macros.svh"

`default_nettype none

module pwm_asserts (
  input logic               mclk,
  input logic               h_reset_n,
  input logic               reg_cs,
  input logic               reg_wr,
  input logic [4:0]         reg_addr,
  input pwm_pkg::reg_word_t reg_wdata,
  input logic               reg_ack,
  input pwm_pkg::ch_mask_t  pwm_out,
  input logic               pwm_intr,
  input pwm_pkg::ch_mask_t  enb,
  input pwm_pkg::ch_mask_t  ovflow
);
  timeunit 1ns;
  timeprecision 100ps;
  import pwm_pkg::*;

  int unsigned fail_cnt = 0;
  logic     wr_land;
  blk_sel_t wr_sel;
  ch_mask_t wr_bits;
  ch_mask_t w1c;
  ch_mask_t frz, frz_d;
  ch_mask_t imask_m, istat_m;
  ch_mask_t prev_out, armed, rise;
  logic     intr_m;
  cnt_t     sh_p [`PWM_NCH];
  cnt_t     sh_h [`PWM_NCH];
  cnt_t     sh_p_d [`PWM_NCH];
  cnt_t     sh_h_d [`PWM_NCH];
  cnt_t     exp_p [`PWM_NCH];
  cnt_t     exp_h [`PWM_NCH];
  cnt_t     hi_n [`PWM_NCH];
  cnt_t     len_n [`PWM_NCH];

  // Host write lands in the ack cycle, cs still held
  assign wr_land = reg_cs & reg_wr & reg_ack;
  assign wr_sel  = reg_addr[4:2];
  assign wr_bits = reg_wdata[`PWM_NCH-1:0];
  assign w1c     = (wr_land && wr_sel == BLK_GLBL && reg_addr[1:0] == `PWM_ADDR_ISTAT) ?
                   wr_bits : '0;
  // Start of a PWM window
  assign rise    = pwm_out & ~prev_out & enb;

  // ----------------------------------------
  // Snooped register model
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      frz     <= '0;
      imask_m <= '0;
      istat_m <= '0;
      intr_m  <= 1'b0;
      for (int i = 0; i < `PWM_NCH; i++) begin
        sh_p[i] <= '0;
        sh_h[i] <= '0;
      end
    end else begin
      if (wr_land && wr_sel == BLK_GLBL && reg_addr[1:0] == `PWM_ADDR_DUPD) begin
        frz <= wr_bits;
      end
      if (wr_land && wr_sel == BLK_GLBL && reg_addr[1:0] == `PWM_ADDR_IMASK) begin
        imask_m <= wr_bits;
      end
      // Wrap sets, write 1 clears, set wins
      istat_m <= (istat_m & ~w1c) | ovflow;
      intr_m  <= |(istat_m & imask_m);
      for (int i = 0; i < `PWM_NCH; i++) begin
        if (wr_land && wr_sel == blk_sel_t'(BLK_CH0 + i)) begin
          if (reg_addr[1:0] == `PWM_ADDR_PERIOD) sh_p[i] <= reg_wdata[`PWM_CW-1:0];
          if (reg_addr[1:0] == `PWM_ADDR_HIGH) sh_h[i] <= reg_wdata[`PWM_CW-1:0];
        end
      end
    end
  end

  // ----------------------------------------
  // Window measurement per channel
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      frz_d    <= '0;
      prev_out <= '0;
      armed    <= '0;
      for (int i = 0; i < `PWM_NCH; i++) begin
        sh_p_d[i] <= '0;
        sh_h_d[i] <= '0;
        exp_p[i]  <= '0;
        exp_h[i]  <= '0;
        hi_n[i]   <= '0;
        len_n[i]  <= '0;
      end
    end else begin
      // Config seen one cycle before the window starts
      frz_d    <= frz;
      prev_out <= pwm_out;
      for (int i = 0; i < `PWM_NCH; i++) begin
        sh_p_d[i] <= sh_p[i];
        sh_h_d[i] <= sh_h[i];
        if (!enb[i]) begin
          armed[i] <= 1'b0;
        end else if (rise[i]) begin
          armed[i] <= 1'b1;
          hi_n[i]  <= cnt_t'(1);
          len_n[i] <= cnt_t'(1);
          // Frozen channel keeps its old timing
          if (!frz_d[i]) begin
            exp_p[i] <= sh_p_d[i];
            exp_h[i] <= sh_h_d[i];
          end
        end else if (armed[i]) begin
          hi_n[i]  <= hi_n[i] + cnt_t'(pwm_out[i]);
          len_n[i] <= len_n[i] + 1'b1;
        end
      end
    end
  end

  // Quiet outputs while in reset
  a_rst: assert property (@(posedge mclk)
    !h_reset_n |-> !reg_ack && pwm_out == '0 && !pwm_intr)
    else begin
      fail_cnt++;
      $error("outputs not low during reset");
    end

  // Ack one cycle after cs, one cycle wide
  a_ack: assert property (@(posedge mclk) disable iff (!h_reset_n)
    $rose(reg_cs) |=> reg_ack ##1 !reg_ack)
    else begin
      fail_cnt++;
      $error("ack did not follow cs by exactly one cycle");
    end

  a_intr: assert property (@(posedge mclk) disable iff (!h_reset_n) pwm_intr == intr_m)
    else begin
      fail_cnt++;
      $error("interrupt differs from masked status model");
    end

  for (genvar g = 0; g < `PWM_NCH; g++) begin : g_win
    // H high cycles in each window of P cycles
    a_win: assert property (@(posedge mclk) disable iff (!h_reset_n)
      rise[g] && armed[g] |-> hi_n[g] == exp_h[g] && len_n[g] == exp_p[g])
      else begin
        fail_cnt++;
        $error("channel %0d window high %0d of %0d, model %0d of %0d",
               g, hi_n[g], len_n[g], exp_h[g], exp_p[g]);
      end
  end

endmodule

bind pwm_subsys pwm_asserts chk_i (
  .mclk      (mclk),
  .h_reset_n (h_reset_n),
  .reg_cs    (reg_cs),
  .reg_wr    (reg_wr),
  .reg_addr  (reg_addr),
  .reg_wdata (reg_wdata),
  .reg_ack   (reg_ack),
  .pwm_out   (pwm_out),
  .pwm_intr  (pwm_intr),
  .enb       (cfg_pwm_enb),
  .ovflow    (pwm_ovflow)
);

`default_nettype wire

// ==== sim/pwm_tb.sv ====
// PWM subsystem testbench with clock, reset, bus tasks, directed and random tests
`include "pwm_macros.svh"

`default_nettype none

module pwm_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import pwm_pkg::*;

  // Several times the summed test lengths
  localparam int CYCLE_LIMIT = 4000;

  logic                 mclk;
  logic                 h_reset_n;
  logic                 reg_cs;
  logic                 reg_wr;
  logic [4:0]           reg_addr;
  reg_word_t            reg_wdata;
  logic [`PWM_DW/8-1:0] reg_be;
  ch_mask_t             gpio_tgr;
  reg_word_t            reg_rdata;
  logic                 reg_ack;
  ch_mask_t             pwm_out;
  logic                 pwm_intr;
  int                   err_cnt = 0;
  int                   cyc_cnt = 0;

  pwm_subsys dut_i (.*);

  initial begin
    mclk = 1'b0;
    forever #10 mclk = ~mclk;
  end

  // Hang guard
  always @(posedge mclk) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt == CYCLE_LIMIT) begin
      $display("Timeout: the run hung and hit the %0d cycle limit", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [4:0] slot_addr(input int slot, input logic [1:0] r);
    return {3'(slot), r};
  endfunction

  // Every wait ends 2 ns after a rising edge
  task automatic next_cycles(input int n);
    repeat (n) @(posedge mclk);
    #2;
  endtask

  task automatic bus_access(input logic wr, input logic [4:0] addr, input reg_word_t wdata,
                            output reg_word_t rdata);
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    next_cycles(1);
    while (!reg_ack) begin
      next_cycles(1);
    end
    rdata = reg_rdata;
    // cs stays up through the ack cycle
    next_cycles(1);
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    next_cycles(1);
  endtask

  task automatic bus_write(input logic [4:0] addr, input reg_word_t wdata);
    reg_word_t unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic check_value(input string name, input reg_word_t exp, input reg_word_t act);
    if (exp !== act) begin
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic read_check(input string name, input logic [4:0] addr, input reg_word_t exp);
    reg_word_t rd;
    bus_access(1'b0, addr, '0, rd);
    check_value(name, exp, rd);
  endtask

  task automatic config_chan(input int ch, input int p, input int h, input int mode);
    bus_write(slot_addr(ch + 1, `PWM_ADDR_PERIOD), p);
    bus_write(slot_addr(ch + 1, `PWM_ADDR_HIGH), h);
    bus_write(slot_addr(ch + 1, `PWM_ADDR_MODE), mode);
  endtask

  initial begin
    int ch;
    int p;
    int h;
    int hi_cnt;
    void'($urandom(32'hf8b2));
    h_reset_n = 1'b0;
    reg_cs    = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_be    = '1;
    gpio_tgr  = '0;
    repeat (8) @(posedge mclk);
    #2;
    h_reset_n = 1'b1;
    next_cycles(1);

    // Reset values of every slot
    for (int s = 0; s <= `PWM_NCH; s++) begin
      for (int r = 0; r < 4; r++) begin
        read_check("reset_regs", slot_addr(s, 2'(r)), '0);
      end
    end

    // ----------------------------------------
    // Config readback and unmapped slot
    // ----------------------------------------
    for (int c = 0; c < `PWM_NCH; c++) begin
      config_chan(c, 32'h1005 + c * 16, 32'h0a00 + c, c % 2);
    end
    for (int c = 0; c < `PWM_NCH; c++) begin
      read_check("period_rb", slot_addr(c + 1, `PWM_ADDR_PERIOD), 32'h1005 + c * 16);
      read_check("high_rb", slot_addr(c + 1, `PWM_ADDR_HIGH), 32'h0a00 + c);
      read_check("mode_rb", slot_addr(c + 1, `PWM_ADDR_MODE), c % 2);
    end
    bus_write(slot_addr(7, 2'd1), 32'hdead_beef);
    read_check("unmapped_rd", slot_addr(7, 2'd1), '0);

    // Random period and high time, windows checked by the bound checker
    for (int n = 0; n < 6; n++) begin
      ch = $urandom_range(`PWM_NCH - 1, 0);
      p  = $urandom_range(20, 4);
      h  = $urandom_range(p, 0);
      config_chan(ch, p, h, 0);
      bus_write(slot_addr(0, `PWM_ADDR_ENB), 1 << ch);
      next_cycles(3 * p + 4);
      bus_write(slot_addr(0, `PWM_ADDR_ENB), 0);
    end

    // One-shot runs one period then drops its enable
    ch = (ch + 1) % `PWM_NCH;
    config_chan(ch, 6, 3, 1);
    bus_write(slot_addr(0, `PWM_ADDR_ENB), 1 << ch);
    // High cycles seen before a second period could end
    hi_cnt = 0;
    for (int k = 0; k < 8; k++) begin
      hi_cnt += pwm_out[ch];
      next_cycles(1);
    end
    check_value("oneshot_high", 3, hi_cnt);
    read_check("oneshot_enb", slot_addr(0, `PWM_ADDR_ENB), '0);
    for (int k = 0; k < 6; k++) begin
      check_value("oneshot_idle", '0, reg_word_t'(pwm_out[ch]));
      next_cycles(1);
    end

    // ----------------------------------------
    // Overflow status and interrupt mask
    // ----------------------------------------
    ch = (ch + 1) % `PWM_NCH;
    config_chan(ch, 5, 2, 0);
    bus_write(slot_addr(0, `PWM_ADDR_ISTAT), 32'h3f);
    bus_write(slot_addr(0, `PWM_ADDR_IMASK), 0);
    bus_write(slot_addr(0, `PWM_ADDR_ENB), 1 << ch);
    next_cycles(8);
    bus_write(slot_addr(0, `PWM_ADDR_ENB), 0);
    read_check("ovf_status", slot_addr(0, `PWM_ADDR_ISTAT), 1 << ch);
    check_value("intr_masked", '0, reg_word_t'(pwm_intr));
    bus_write(slot_addr(0, `PWM_ADDR_IMASK), 1 << ch);
    next_cycles(2);
    check_value("intr_unmasked", 1, reg_word_t'(pwm_intr));
    bus_write(slot_addr(0, `PWM_ADDR_ISTAT), 1 << ch);
    read_check("status_clear", slot_addr(0, `PWM_ADDR_ISTAT), '0);
    check_value("intr_clear", '0, reg_word_t'(pwm_intr));
    bus_write(slot_addr(0, `PWM_ADDR_IMASK), 0);

    // Trigger enable, then freeze around a high time change
    ch = (ch + 1) % `PWM_NCH;
    config_chan(ch, 10, 3, 0);
    gpio_tgr = ch_mask_t'(1 << ch);
    next_cycles(1);
    gpio_tgr = '0;
    next_cycles(1);
    read_check("gpio_enb", slot_addr(0, `PWM_ADDR_ENB), 1 << ch);
    next_cycles(20);
    bus_write(slot_addr(0, `PWM_ADDR_DUPD), 1 << ch);
    bus_write(slot_addr(ch + 1, `PWM_ADDR_HIGH), 7);
    next_cycles(30);
    bus_write(slot_addr(0, `PWM_ADDR_DUPD), 0);
    next_cycles(30);
    read_check("frozen_high_rb", slot_addr(ch + 1, `PWM_ADDR_HIGH), 7);
    bus_write(slot_addr(0, `PWM_ADDR_ENB), 0);
    next_cycles(4);

    $display("Errors: %0d, assertion failures: %0d", err_cnt, dut_i.chk_i.fail_cnt);
    if (err_cnt == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/pwm_pkg.sv
logic/pwm_reg_if.sv
logic/pwm_bus_decode.sv
logic/pwm_glbl_reg.sv
logic/pwm_chan.sv
logic/pwm_subsys.sv
sim/pwm_asserts.sv
sim/pwm_tb.sv

// ==== Bender.yml ====
package:
  name: pwm_subsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/pwm_pkg.sv
      - logic/pwm_reg_if.sv
      - logic/pwm_bus_decode.sv
      - logic/pwm_glbl_reg.sv
      - logic/pwm_chan.sv
      - logic/pwm_subsys.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/pwm_asserts.sv
      - sim/pwm_tb.sv
